//--- rtl/cpuPkg.sv
package cpuPkg;

  localparam int dataBits = 32;
  localparam int regNoBits = 4;
  localparam int immBits = 16;

  localparam logic [dataBits-1:0] startPc = 'h100;
  localparam logic [dataBits-1:0] instSize = 4;

  // Memories are word arrays indexed by byte address bits [addrBits-1:2]
  localparam int imemAddrBits = 16;
  localparam int dmemAddrBits = 16;

  // Memory-mapped I/O
  localparam logic [dataBits-1:0] addrHex = 'hFFFFF000;
  localparam logic [dataBits-1:0] addrLedr = 'hFFFFF020;
  localparam logic [dataBits-1:0] addrKey = 'hFFFFF080;

  localparam int hexBits = 24;
  localparam int ledrBits = 10;
  localparam int keyBits = 4;

  localparam logic [hexBits-1:0] hexResetValue = 'hFEDEAD;

  // Primary opcodes, op1Alur doubles as the NOP encoding
  typedef enum logic [5:0] {
    op1Alur = 6'b000000,
    op1Beq  = 6'b001000,
    op1Blt  = 6'b001001,
    op1Ble  = 6'b001010,
    op1Bne  = 6'b001011,
    op1Jal  = 6'b001100,
    op1Lw   = 6'b010010,
    op1Sw   = 6'b011010,
    op1Addi = 6'b100000,
    op1Andi = 6'b100100,
    op1Ori  = 6'b100101,
    op1Xori = 6'b100110
  } op1Enum;

  // Secondary opcodes for register-register ALU operations
  typedef enum logic [7:0] {
    op2Eq   = 8'b00001000,
    op2Lt   = 8'b00001001,
    op2Le   = 8'b00001010,
    op2Ne   = 8'b00001011,
    op2Add  = 8'b00100000,
    op2And  = 8'b00100100,
    op2Or   = 8'b00100101,
    op2Xor  = 8'b00100110,
    op2Sub  = 8'b00101000,
    op2Nand = 8'b00101100,
    op2Nor  = 8'b00101101,
    op2Xnor = 8'b00101110,
    op2Rshf = 8'b00110000,
    op2Lshf = 8'b00110001
  } op2Enum;

  typedef struct packed {
    logic isBranch;
    logic isJump;
    logic readMem;
    logic writeMem;
    logic writeReg;
  } ctrlBundle;

  typedef struct packed {
    logic [dataBits-1:0]  pc;
    op1Enum               op1;
    op2Enum               op2;
    logic [dataBits-1:0]  rsValue;
    logic [dataBits-1:0]  rtValue;
    logic [dataBits-1:0]  imm;
    logic [regNoBits-1:0] dest;
    ctrlBundle            ctrl;
  } decodedInst;

  typedef struct packed {
    logic [dataBits-1:0]  aluResult;
    logic [dataBits-1:0]  storeValue;
    logic [regNoBits-1:0] dest;
    logic                 readMem;
    logic                 writeMem;
    logic                 writeReg;
  } exMemBundle;

  typedef struct packed {
    logic [dataBits-1:0]  value;
    logic [regNoBits-1:0] regNo;
    logic                 enable;
  } writeBack;

  typedef struct packed {
    logic                taken;
    logic [dataBits-1:0] target;
  } redirect;

endpackage

//--- rtl/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         loadEnable,
  input  logic [cpuPkg::dataBits-1:0]  loadAddr,
  input  logic [cpuPkg::dataBits-1:0]  loadData,
  input  logic                         stall,
  input  cpuPkg::redirect              redirect,
  output logic [cpuPkg::dataBits-1:0]  inst,
  output logic [cpuPkg::dataBits-1:0]  instPc
);

  localparam int imemWords = 2 ** (cpuPkg::imemAddrBits - 2);

  logic [cpuPkg::dataBits-1:0] imem [imemWords];
  logic [cpuPkg::dataBits-1:0] pc;
  logic [cpuPkg::dataBits-1:0] pcNext;
  logic [cpuPkg::dataBits-1:0] fetched;

  assign pcNext = pc + cpuPkg::instSize;
  assign fetched = imem[pc[cpuPkg::imemAddrBits-1:2]];

  // Program image is written only while the core is held in reset
  always_ff @(posedge clk) begin
    if (reset && loadEnable) begin
      imem[loadAddr[cpuPkg::imemAddrBits-1:2]] <= loadData;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= cpuPkg::startPc;
    end else if (redirect.taken) begin
      pc <= redirect.target;
    end else if (!stall) begin
      pc <= pcNext;
    end
  end

  // Fetch latch; instPc carries the address of the next instruction
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      inst <= '0;
      instPc <= '0;
    end else if (redirect.taken) begin
      // Squash the younger instruction
      inst <= '0;
      instPc <= '0;
    end else if (!stall) begin
      inst <= fetched;
      instPc <= pcNext;
    end
  end

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [cpuPkg::regNoBits-1:0] rsNo,
  input  logic [cpuPkg::regNoBits-1:0] rtNo,
  output logic [cpuPkg::dataBits-1:0]  rsValue,
  output logic [cpuPkg::dataBits-1:0]  rtValue,
  input  cpuPkg::writeBack             wb
);

  localparam int regWords = 2 ** cpuPkg::regNoBits;

  logic [cpuPkg::dataBits-1:0] regs [regWords];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < regWords; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.enable) begin
      regs[wb.regNo] <= wb.value;
    end
  end

  // A read of the register being written sees the new value
  assign rsValue = (wb.enable && wb.regNo == rsNo) ? wb.value : regs[rsNo];
  assign rtValue = (wb.enable && wb.regNo == rtNo) ? wb.value : regs[rtNo];

endmodule

//--- rtl/decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [cpuPkg::dataBits-1:0]  inst,
  input  logic [cpuPkg::dataBits-1:0]  instPc,
  input  cpuPkg::redirect              redirect,
  input  logic [cpuPkg::regNoBits-1:0] exDest,
  input  logic                         exWrite,
  input  logic [cpuPkg::regNoBits-1:0] memDest,
  input  logic                         memWrite,
  input  cpuPkg::writeBack             wb,
  output logic                         stall,
  output cpuPkg::decodedInst           decoded
);

  cpuPkg::op1Enum               op1;
  cpuPkg::op2Enum               op2;
  logic [cpuPkg::immBits-1:0]   immField;
  logic [cpuPkg::regNoBits-1:0] rd;
  logic [cpuPkg::regNoBits-1:0] rs;
  logic [cpuPkg::regNoBits-1:0] rt;
  logic [cpuPkg::dataBits-1:0]  rsValue;
  logic [cpuPkg::dataBits-1:0]  rtValue;
  logic [cpuPkg::dataBits-1:0]  immExt;
  logic [cpuPkg::regNoBits-1:0] dest;
  cpuPkg::ctrlBundle            ctrl;
  logic                         writesReg;
  logic                         readsRs;
  logic                         readsRt;
  logic                         rsBusy;
  logic                         rtBusy;

  assign op1 = cpuPkg::op1Enum'(inst[31:26]);
  assign op2 = cpuPkg::op2Enum'(inst[25:18]);
  assign immField = inst[23:8];
  assign rd = inst[11:8];
  assign rs = inst[7:4];
  assign rt = inst[3:0];

  assign immExt = {{(cpuPkg::dataBits - cpuPkg::immBits){immField[cpuPkg::immBits-1]}}, immField};

  regFile u_regFile (
    .clk     (clk),
    .reset   (reset),
    .rsNo    (rs),
    .rtNo    (rt),
    .rsValue (rsValue),
    .rtValue (rtValue),
    .wb      (wb)
  );

  // Control and source usage per primary opcode
  always_comb begin
    ctrl = '0;
    writesReg = 1'b0;
    readsRs = 1'b0;
    readsRt = 1'b0;
    case (op1)
      cpuPkg::op1Alur: begin
        writesReg = 1'b1;
        readsRs = 1'b1;
        readsRt = 1'b1;
      end
      cpuPkg::op1Beq, cpuPkg::op1Blt, cpuPkg::op1Ble, cpuPkg::op1Bne: begin
        ctrl.isBranch = 1'b1;
        readsRs = 1'b1;
        readsRt = 1'b1;
      end
      cpuPkg::op1Jal: begin
        ctrl.isJump = 1'b1;
        writesReg = 1'b1;
        readsRs = 1'b1;
      end
      cpuPkg::op1Lw: begin
        ctrl.readMem = 1'b1;
        writesReg = 1'b1;
        readsRs = 1'b1;
      end
      cpuPkg::op1Sw: begin
        ctrl.writeMem = 1'b1;
        readsRs = 1'b1;
        readsRt = 1'b1;
      end
      cpuPkg::op1Addi, cpuPkg::op1Andi, cpuPkg::op1Ori, cpuPkg::op1Xori: begin
        writesReg = 1'b1;
        readsRs = 1'b1;
      end
      default: begin
        writesReg = 1'b0;
      end
    endcase
    // r0 is never written, so the NOP encoding leaves it at zero
    ctrl.writeReg = writesReg && (dest != '0);
  end

  assign dest = (op1 == cpuPkg::op1Alur) ? rd : rt;

  // Compare sources with the three younger-than-writeback destinations
  assign rsBusy = (rs != '0) &&
                  ((decoded.ctrl.writeReg && decoded.dest == rs) ||
                   (exWrite && exDest == rs) ||
                   (memWrite && memDest == rs));
  assign rtBusy = (rt != '0) &&
                  ((decoded.ctrl.writeReg && decoded.dest == rt) ||
                   (exWrite && exDest == rt) ||
                   (memWrite && memDest == rt));

  assign stall = (readsRs && rsBusy) || (readsRt && rtBusy);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      decoded <= '0;
    end else if (stall || redirect.taken) begin
      decoded <= '0;
    end else begin
      decoded.pc <= instPc;
      decoded.op1 <= op1;
      decoded.op2 <= op2;
      decoded.rsValue <= rsValue;
      decoded.rtValue <= rtValue;
      decoded.imm <= immExt;
      decoded.dest <= dest;
      decoded.ctrl <= ctrl;
    end
  end

endmodule

//--- rtl/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
  input  logic                 clk,
  input  logic                 reset,
  input  cpuPkg::decodedInst   decoded,
  output cpuPkg::redirect      redirect,
  output cpuPkg::exMemBundle   exOut
);

  logic signed [cpuPkg::dataBits-1:0] rsS;
  logic signed [cpuPkg::dataBits-1:0] rtS;
  logic signed [cpuPkg::dataBits-1:0] immS;
  logic [cpuPkg::dataBits-1:0]        aluResult;
  logic                               branchCond;
  logic [cpuPkg::dataBits-1:0]        immWords;

  assign rsS = decoded.rsValue;
  assign rtS = decoded.rtValue;
  assign immS = decoded.imm;

  always_comb begin
    aluResult = '0;
    case (decoded.op1)
      cpuPkg::op1Alur: begin
        case (decoded.op2)
          cpuPkg::op2Eq:   aluResult = cpuPkg::dataBits'(rsS == rtS);
          cpuPkg::op2Lt:   aluResult = cpuPkg::dataBits'(rsS < rtS);
          cpuPkg::op2Le:   aluResult = cpuPkg::dataBits'(rsS <= rtS);
          cpuPkg::op2Ne:   aluResult = cpuPkg::dataBits'(rsS != rtS);
          cpuPkg::op2Add:  aluResult = rsS + rtS;
          cpuPkg::op2Sub:  aluResult = rsS - rtS;
          cpuPkg::op2And:  aluResult = rsS & rtS;
          cpuPkg::op2Or:   aluResult = rsS | rtS;
          cpuPkg::op2Xor:  aluResult = rsS ^ rtS;
          cpuPkg::op2Nand: aluResult = ~(rsS & rtS);
          cpuPkg::op2Nor:  aluResult = ~(rsS | rtS);
          cpuPkg::op2Xnor: aluResult = ~(rsS ^ rtS);
          // Shift amount is the whole rt value, large shifts saturate
          cpuPkg::op2Rshf: aluResult = rsS >>> decoded.rtValue;
          cpuPkg::op2Lshf: aluResult = rsS <<< decoded.rtValue;
          default:         aluResult = '0;
        endcase
      end
      cpuPkg::op1Lw, cpuPkg::op1Sw, cpuPkg::op1Addi: aluResult = rsS + immS;
      cpuPkg::op1Andi: aluResult = rsS & immS;
      cpuPkg::op1Ori:  aluResult = rsS | immS;
      cpuPkg::op1Xori: aluResult = rsS ^ immS;
      // Return address, already the instruction's address plus 4
      cpuPkg::op1Jal:  aluResult = decoded.pc;
      default:         aluResult = '0;
    endcase
  end

  always_comb begin
    case (decoded.op1)
      cpuPkg::op1Beq: branchCond = (rsS == rtS);
      cpuPkg::op1Blt: branchCond = (rsS < rtS);
      cpuPkg::op1Ble: branchCond = (rsS <= rtS);
      cpuPkg::op1Bne: branchCond = (rsS != rtS);
      default:        branchCond = 1'b0;
    endcase
  end

  assign immWords = decoded.imm << 2;

  // Resolved here and taken by fetch on the next edge
  assign redirect.taken = (decoded.ctrl.isBranch && branchCond) || decoded.ctrl.isJump;
  assign redirect.target = decoded.ctrl.isJump ? decoded.rsValue + immWords
                                               : decoded.pc + immWords;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      exOut <= '0;
    end else begin
      exOut.aluResult <= aluResult;
      exOut.storeValue <= decoded.rtValue;
      exOut.dest <= decoded.dest;
      exOut.readMem <= decoded.ctrl.readMem;
      exOut.writeMem <= decoded.ctrl.writeMem;
      exOut.writeReg <= decoded.ctrl.writeReg;
    end
  end

endmodule

//--- rtl/memoryUnit.sv
`timescale 1ns/1ps

module memoryUnit (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        loadEnable,
  input  logic [cpuPkg::dataBits-1:0] loadAddr,
  input  logic [cpuPkg::dataBits-1:0] loadData,
  input  cpuPkg::exMemBundle          exIn,
  input  logic [cpuPkg::keyBits-1:0]  key,
  output logic [cpuPkg::hexBits-1:0]  hex,
  output logic [cpuPkg::ledrBits-1:0] ledr,
  output cpuPkg::writeBack            wb
);

  localparam int dmemWords = 2 ** (cpuPkg::dmemAddrBits - 2);

  logic [cpuPkg::dataBits-1:0] dmem [dmemWords];
  logic [cpuPkg::dataBits-1:0] addr;
  logic                        hexSel;
  logic                        ledrSel;
  logic [cpuPkg::dataBits-1:0] readValue;

  assign addr = exIn.aluResult;
  assign hexSel = (addr == cpuPkg::addrHex);
  assign ledrSel = (addr == cpuPkg::addrLedr);

  // Load port during reset, program stores afterwards
  always_ff @(posedge clk) begin
    if (reset) begin
      if (loadEnable) begin
        dmem[loadAddr[cpuPkg::dmemAddrBits-1:2]] <= loadData;
      end
    end else if (exIn.writeMem && !hexSel && !ledrSel) begin
      dmem[addr[cpuPkg::dmemAddrBits-1:2]] <= exIn.storeValue;
    end
  end

  // KEY buttons are active low
  assign readValue = (addr == cpuPkg::addrKey)
                   ? {{(cpuPkg::dataBits - cpuPkg::keyBits){1'b0}}, ~key}
                   : dmem[addr[cpuPkg::dmemAddrBits-1:2]];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex <= cpuPkg::hexResetValue;
      ledr <= '0;
    end else if (exIn.writeMem) begin
      if (hexSel) begin
        hex <= exIn.storeValue[cpuPkg::hexBits-1:0];
      end
      if (ledrSel) begin
        ledr <= exIn.storeValue[cpuPkg::ledrBits-1:0];
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb <= '0;
    end else begin
      wb.value <= exIn.readMem ? readValue : exIn.aluResult;
      wb.regNo <= exIn.dest;
      wb.enable <= exIn.writeReg;
    end
  end

endmodule

//--- rtl/pipelineCpu.sv
`timescale 1ns/1ps

module pipelineCpu (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        loadEnable,
  input  logic [cpuPkg::dataBits-1:0] loadAddr,
  input  logic [cpuPkg::dataBits-1:0] loadData,
  input  logic [cpuPkg::keyBits-1:0]  key,
  output logic [cpuPkg::hexBits-1:0]  hex,
  output logic [cpuPkg::ledrBits-1:0] ledr
);

  logic [cpuPkg::dataBits-1:0] inst;
  logic [cpuPkg::dataBits-1:0] instPc;
  logic                        stall;
  cpuPkg::redirect             redirectBus;
  cpuPkg::decodedInst          decodedBus;
  cpuPkg::exMemBundle          exBus;
  cpuPkg::writeBack            wbBus;

  fetchUnit u_fetchUnit (
    .clk        (clk),
    .reset      (reset),
    .loadEnable (loadEnable),
    .loadAddr   (loadAddr),
    .loadData   (loadData),
    .stall      (stall),
    .redirect   (redirectBus),
    .inst       (inst),
    .instPc     (instPc)
  );

  // Writeback feeds the register file inside decode
  decodeUnit u_decodeUnit (
    .clk      (clk),
    .reset    (reset),
    .inst     (inst),
    .instPc   (instPc),
    .redirect (redirectBus),
    .exDest   (exBus.dest),
    .exWrite  (exBus.writeReg),
    .memDest  (wbBus.regNo),
    .memWrite (wbBus.enable),
    .wb       (wbBus),
    .stall    (stall),
    .decoded  (decodedBus)
  );

  executeUnit u_executeUnit (
    .clk      (clk),
    .reset    (reset),
    .decoded  (decodedBus),
    .redirect (redirectBus),
    .exOut    (exBus)
  );

  memoryUnit u_memoryUnit (
    .clk        (clk),
    .reset      (reset),
    .loadEnable (loadEnable),
    .loadAddr   (loadAddr),
    .loadData   (loadData),
    .exIn       (exBus),
    .key        (key),
    .hex        (hex),
    .ledr       (ledr),
    .wb         (wbBus)
  );

endmodule

//--- tb/tbPipelineCpu.sv
`timescale 1ns/1ps

module tbPipelineCpu;

  logic                        clk;
  logic                        reset;
  logic                        loadEnable;
  logic [cpuPkg::dataBits-1:0] loadAddr;
  logic [cpuPkg::dataBits-1:0] loadData;
  logic [cpuPkg::keyBits-1:0]  key;
  logic [cpuPkg::hexBits-1:0]  hex;
  logic [cpuPkg::ledrBits-1:0] ledr;

  // Program words from startPc and the HEX value expected at each LEDR step
  logic [31:0] prog [$];
  logic [31:0] expHex [$];
  logic [31:0] lfsrState;
  int          cycles;
  int          cycleLimit;

  pipelineCpu u_pipelineCpu (
    .clk        (clk),
    .reset      (reset),
    .loadEnable (loadEnable),
    .loadAddr   (loadAddr),
    .loadData   (loadData),
    .key        (key),
    .hex        (hex),
    .ledr       (ledr)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("Timeout: the program did not finish within %0d clock cycles", cycleLimit);
      $display("*** FAILED ***");
      $fatal(1, "Simulation timed out");
    end
  end

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s got %h expected %h", $time, what, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] randomBits(int count);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < count; i++) begin
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic logic [31:0] sext(logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic logic [31:0] alurInst(cpuPkg::op2Enum op, int rd, int rs, int rt);
    return {6'b0, op, 6'b0, 4'(rd), 4'(rs), 4'(rt)};
  endfunction

  function automatic logic [31:0] immInst(cpuPkg::op1Enum op, logic [15:0] imm, int rs, int rt);
    return {op, 2'b0, imm, 4'(rs), 4'(rt)};
  endfunction

  // Step number into r15, then value to HEX and step to LEDR
  function automatic void addReport(int valueReg, logic [31:0] value);
    expHex.push_back(value);
    prog.push_back(immInst(cpuPkg::op1Addi, 16'(expHex.size()), 0, 15));
    prog.push_back(immInst(cpuPkg::op1Sw, 16'(cpuPkg::addrHex), 0, valueReg));
    prog.push_back(immInst(cpuPkg::op1Sw, 16'(cpuPkg::addrLedr), 0, 15));
  endfunction

  // Two stores of the r14 marker to LEDR that must never execute
  function automatic void addMarkers();
    prog.push_back(immInst(cpuPkg::op1Sw, 16'(cpuPkg::addrLedr), 0, 14));
    prog.push_back(immInst(cpuPkg::op1Sw, 16'(cpuPkg::addrLedr), 0, 14));
  endfunction

  function automatic logic [31:0] aluModel(cpuPkg::op2Enum op, logic [31:0] x, logic [31:0] y);
    case (op)
      cpuPkg::op2Eq:   return {31'b0, x == y};
      cpuPkg::op2Lt:   return {31'b0, $signed(x) < $signed(y)};
      cpuPkg::op2Le:   return {31'b0, $signed(x) <= $signed(y)};
      cpuPkg::op2Ne:   return {31'b0, x != y};
      cpuPkg::op2Add:  return x + y;
      cpuPkg::op2Sub:  return x - y;
      cpuPkg::op2And:  return x & y;
      cpuPkg::op2Or:   return x | y;
      cpuPkg::op2Xor:  return x ^ y;
      cpuPkg::op2Nand: return ~(x & y);
      cpuPkg::op2Nor:  return ~(x | y);
      cpuPkg::op2Xnor: return ~(x ^ y);
      cpuPkg::op2Rshf: return $signed(x) >>> y[4:0];
      cpuPkg::op2Lshf: return x << y[4:0];
      default:         return '0;
    endcase
  endfunction

  function automatic logic [31:0] immModel(cpuPkg::op1Enum op, logic [31:0] x, logic [15:0] imm);
    case (op)
      cpuPkg::op1Addi: return x + sext(imm);
      cpuPkg::op1Andi: return x & sext(imm);
      cpuPkg::op1Ori:  return x | sext(imm);
      cpuPkg::op1Xori: return x ^ sext(imm);
      default:         return '0;
    endcase
  endfunction

  // Load the image under reset, then follow LEDR to the last step
  task automatic runProgram(input logic [31:0] dataAddr, input logic [31:0] dataWord,
                            input logic [3:0] keyIn);
    int         step;
    logic [9:0] lastLedr;
    // Final self loop, padded so the squashed fetches see NOPs
    prog.push_back(immInst(cpuPkg::op1Beq, 16'hFFFF, 0, 0));
    prog.push_back('0);
    prog.push_back('0);
    cycleLimit += 4 * prog.size() + 50;
    @(posedge clk);
    reset <= 1'b1;
    key <= keyIn;
    for (int i = 0; i <= prog.size(); i++) begin
      @(posedge clk);
      loadEnable <= 1'b1;
      loadAddr <= (i < prog.size()) ? cpuPkg::startPc + 4 * i : dataAddr;
      loadData <= (i < prog.size()) ? prog[i] : dataWord;
      @(negedge clk);
      checkValue(32'(hex), 32'(cpuPkg::hexResetValue), "HEX under reset");
      checkValue(32'(ledr), '0, "LEDR under reset");
    end
    @(posedge clk);
    reset <= 1'b0;
    loadEnable <= 1'b0;
    step = 0;
    lastLedr = '0;
    while (step < expHex.size()) begin
      @(negedge clk);
      if (ledr != lastLedr) begin
        step++;
        checkValue(32'(ledr), 32'(step), "LEDR step");
        checkValue(32'(hex), expHex[step - 1] & 32'h00FF_FFFF, "HEX result");
        lastLedr = ledr;
      end
    end
    prog.delete();
    expHex.delete();
  endtask

  task automatic resetTest();
    repeat (3) begin
      @(negedge clk);
      checkValue(32'(hex), 32'(cpuPkg::hexResetValue), "HEX after reset");
      checkValue(32'(ledr), '0, "LEDR after reset");
    end
  endtask

  task automatic aluTest();
    logic [15:0]    immA;
    logic [15:0]    immB;
    logic [4:0]     shift;
    int             rt;
    cpuPkg::op2Enum op;
    immA = 16'(randomBits(16));
    immB = 16'(randomBits(16));
    shift = 5'(randomBits(5));
    prog.push_back(immInst(cpuPkg::op1Addi, immA, 0, 1));
    prog.push_back(immInst(cpuPkg::op1Addi, immB, 0, 2));
    prog.push_back(immInst(cpuPkg::op1Addi, {11'b0, shift}, 0, 3));
    op = op.first();
    for (int k = 0; k < op.num(); k++) begin
      // Shifts take their amount from r3
      rt = (op == cpuPkg::op2Rshf || op == cpuPkg::op2Lshf) ? 3 : 2;
      prog.push_back(alurInst(op, 4, 1, rt));
      addReport(4, aluModel(op, sext(immA), (rt == 3) ? {27'b0, shift} : sext(immB)));
      op = op.next();
    end
    runProgram(32'h0C00, '0, '0);
  endtask

  task automatic immediateTest();
    logic [15:0]    hi;
    logic [7:0]     lo;
    logic [15:0]    imm;
    logic [31:0]    base;
    cpuPkg::op1Enum ops [4];
    hi = 16'(randomBits(16));
    lo = 8'(randomBits(8));
    base = (sext(hi) << 8) ^ {24'b0, lo};
    ops = '{cpuPkg::op1Addi, cpuPkg::op1Andi, cpuPkg::op1Ori, cpuPkg::op1Xori};
    prog.push_back(immInst(cpuPkg::op1Addi, hi, 0, 1));
    prog.push_back(immInst(cpuPkg::op1Addi, 16'd8, 0, 5));
    prog.push_back(alurInst(cpuPkg::op2Lshf, 1, 1, 5));
    prog.push_back(immInst(cpuPkg::op1Xori, {8'b0, lo}, 1, 1));
    // Each operation once with a negative and once with a positive immediate
    for (int k = 0; k < 8; k++) begin
      imm = (k % 2 == 0) ? {1'b1, 15'(randomBits(15))} : 16'(randomBits(15));
      prog.push_back(immInst(ops[k / 2], imm, 1, 2));
      addReport(2, immModel(ops[k / 2], base, imm));
    end
    runProgram(32'h0C00, '0, '0);
  endtask

  task automatic hazardTest();
    logic [15:0] v1;
    logic [15:0] v2;
    logic [15:0] v3;
    logic [31:0] x3;
    logic [31:0] x4;
    logic [31:0] x6;
    v1 = 16'(randomBits(16));
    v2 = 16'(randomBits(16));
    v3 = 16'(randomBits(16));
    // Sequential reference values
    x3 = (sext(v1) + sext(v2)) - sext(v1);
    x4 = sext(v1) ^ x3;
    x6 = x4 + sext(v3);
    prog.push_back(immInst(cpuPkg::op1Addi, 16'h07F0, 0, 8));
    prog.push_back(immInst(cpuPkg::op1Addi, v1, 0, 1));
    prog.push_back(immInst(cpuPkg::op1Addi, v2, 1, 2));
    prog.push_back(alurInst(cpuPkg::op2Sub, 3, 2, 1));
    prog.push_back(alurInst(cpuPkg::op2Xor, 4, 1, 3));
    prog.push_back(immInst(cpuPkg::op1Sw, 16'h0010, 8, 4));
    prog.push_back(immInst(cpuPkg::op1Lw, 16'h0010, 8, 5));
    // Load-use pair
    prog.push_back(immInst(cpuPkg::op1Addi, v3, 5, 6));
    prog.push_back(alurInst(cpuPkg::op2Add, 7, 6, 5));
    addReport(4, x4);
    addReport(7, x6 + x4);
    runProgram(32'h0C00, '0, '0);
  endtask

  task automatic controlTest();
    cpuPkg::op1Enum kinds [4];
    int             takenRt [4];
    int             notRs [4];
    int             notRt [4];
    logic [15:0]    code;
    logic [31:0]    retAddr;
    kinds = '{cpuPkg::op1Beq, cpuPkg::op1Blt, cpuPkg::op1Ble, cpuPkg::op1Bne};
    takenRt = '{1, 2, 1, 2};
    notRs = '{1, 2, 2, 1};
    notRt = '{2, 1, 1, 1};
    // r1 is negative so blt and ble see a signed compare
    prog.push_back(immInst(cpuPkg::op1Addi, 16'hFFFB, 0, 1));
    prog.push_back(immInst(cpuPkg::op1Addi, 16'd7, 0, 2));
    prog.push_back(immInst(cpuPkg::op1Addi, 16'h03FF, 0, 14));
    for (int k = 0; k < 4; k++) begin
      // Taken branch skips the two marker stores
      code = 16'(16 * k + 1);
      prog.push_back(immInst(cpuPkg::op1Addi, code, 0, 6));
      prog.push_back(immInst(kinds[k], 16'd2, 1, takenRt[k]));
      addMarkers();
      addReport(6, {16'b0, code});
      // Not-taken branch falls through to the value update
      code = 16'(16 * k + 2);
      prog.push_back(immInst(cpuPkg::op1Addi, 16'd0, 0, 6));
      prog.push_back(immInst(kinds[k], 16'd1, notRs[k], notRt[k]));
      prog.push_back(immInst(cpuPkg::op1Addi, code, 0, 6));
      addReport(6, {16'b0, code});
    end
    retAddr = cpuPkg::startPc + 4 * prog.size() + 4;
    prog.push_back(immInst(cpuPkg::op1Jal, 16'((retAddr + 8) >> 2), 0, 7));
    addMarkers();
    addReport(7, retAddr);
    runProgram(32'h0C00, '0, '0);
  endtask

  task automatic memoryTest();
    logic [15:0] hi;
    logic [14:0] lo;
    logic [31:0] word;
    logic [31:0] imageWord;
    logic [3:0]  keyIn;
    hi = 16'(randomBits(16));
    lo = 15'(randomBits(15));
    imageWord = randomBits(32);
    keyIn = 4'(randomBits(4));
    word = {hi, 1'b0, lo};
    prog.push_back(immInst(cpuPkg::op1Addi, hi, 0, 1));
    prog.push_back(immInst(cpuPkg::op1Addi, 16'd16, 0, 5));
    prog.push_back(alurInst(cpuPkg::op2Lshf, 1, 1, 5));
    prog.push_back(immInst(cpuPkg::op1Ori, {1'b0, lo}, 1, 1));
    prog.push_back(immInst(cpuPkg::op1Addi, 16'd8, 0, 9));
    prog.push_back(immInst(cpuPkg::op1Sw, 16'h0900, 0, 1));
    prog.push_back(immInst(cpuPkg::op1Lw, 16'h0900, 0, 3));
    // Top byte shows up after a right shift by 8
    addReport(3, word);
    prog.push_back(alurInst(cpuPkg::op2Rshf, 4, 3, 9));
    addReport(4, {8'b0, word[31:8]});
    prog.push_back(immInst(cpuPkg::op1Lw, 16'h0A00, 0, 3));
    addReport(3, imageWord);
    prog.push_back(alurInst(cpuPkg::op2Rshf, 4, 3, 9));
    addReport(4, {8'b0, imageWord[31:8]});
    prog.push_back(immInst(cpuPkg::op1Lw, 16'(cpuPkg::addrKey), 0, 3));
    addReport(3, {28'b0, ~keyIn});
    runProgram(32'h0A00, imageWord, keyIn);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    loadEnable = 1'b0;
    loadAddr = '0;
    loadData = '0;
    key = '0;
    lfsrState = 32'd93289;
    cycles = 0;
    cycleLimit = 50;
    resetTest();
    aluTest();
    immediateTest();
    hazardTest();
    controlTest();
    memoryTest();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- flist.f
rtl/cpuPkg.sv
rtl/fetchUnit.sv
rtl/regFile.sv
rtl/decodeUnit.sv
rtl/executeUnit.sv
rtl/memoryUnit.sv
rtl/pipelineCpu.sv
tb/tbPipelineCpu.sv
